//--- source/ahb_cfg.svh
`ifndef AHB_CFG_SVH
`define AHB_CFG_SVH

// Bus widths
`define AHB_ADDR_W 32
`define AHB_DATA_W 32

// Slave ports on the node
`define AHB_NB_SLAVES 2

// SRAM region, 1 KiB at the bottom of the map
`define SRAM_BASE  32'h0000_0000
`define SRAM_SIZE  32'h0000_0400
`define SRAM_DEPTH 256

// Register region, 16 word offsets
`define REG_BASE 32'h0001_0000
`define REG_SIZE 32'h0000_0040

// Register slave timing and identity
`define REG_WAIT     2
`define REG_ID_VALUE 32'hA4B0_0101

`endif

//--- source/ahb_bus_pkg.sv
`include "ahb_cfg.svh"

package ahb_bus_pkg;

  // Transfer type as driven on HTRANS
  // Only NONSEQ and SEQ carry a transfer
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Transfer sizes up to the bus width
  typedef enum logic [2:0] {
    BYTE = 3'b000,
    HALF = 3'b001,
    WORD = 3'b010
  } hsize_e;

  // Master request
  // Address phase fields first, write data last
  typedef struct packed {
    logic [`AHB_ADDR_W-1:0] haddr;
    logic                   hwrite;
    htrans_e                htrans;
    hsize_e                 hsize;
    logic [2:0]             hburst;
    logic [3:0]             hprot;
    logic                   hmastlock;
    logic [`AHB_DATA_W-1:0] hwdata;
  } ahb_req_t;

  // Response back to the master
  // From a slave the hready field is its HREADYOUT
  typedef struct packed {
    logic [`AHB_DATA_W-1:0] hrdata;
    logic                   hresp;
    logic                   hready;
  } ahb_rsp_t;

endpackage

//--- source/ahb_map_pkg.sv
`include "ahb_cfg.svh"

package ahb_map_pkg;

  // Slave port numbers on the node
  // Select bits and response entries follow this order
  typedef enum logic [$clog2(`AHB_NB_SLAVES)-1:0] {
    SLV_SRAM = 'd0,
    SLV_REG  = 'd1
  } slave_idx_e;

  // Word offsets inside the register region
  // Offsets past OFF_SCR2 are unimplemented
  typedef enum logic [$clog2(`REG_SIZE/4)-1:0] {
    OFF_ID   = 'd0,
    OFF_SCR0 = 'd1,
    OFF_SCR1 = 'd2,
    OFF_SCR2 = 'd3
  } reg_off_e;

endpackage

//--- source/ahb_node.sv
`timescale 1ns/1ps
`include "ahb_cfg.svh"

module ahb_node (
  input  logic                       hclk,
  input  logic                       hreset_n,
  // Single master side
  input  ahb_bus_pkg::ahb_req_t      req_i,
  output ahb_bus_pkg::ahb_rsp_t      rsp_o,
  // Slave side
  output ahb_bus_pkg::ahb_req_t      slv_req_o,
  output logic [`AHB_NB_SLAVES-1:0]  slv_sel_o,
  output logic                       hready_o,
  input  ahb_bus_pkg::ahb_rsp_t      slv_rsp_i [`AHB_NB_SLAVES]
);
  import ahb_bus_pkg::*;
  import ahb_map_pkg::*;

  // Select of the slave owning the current data phase
  logic [`AHB_NB_SLAVES-1:0] data_sel_q;

  // Region hit for a power-of-two sized, size-aligned region
  function automatic logic in_region(
    input logic [`AHB_ADDR_W-1:0] addr,
    input logic [`AHB_ADDR_W-1:0] base,
    input logic [`AHB_ADDR_W-1:0] size
  );
    return (addr & ~(size - 1'b1)) == base;
  endfunction

  // Address phase decode
  // Purely combinational from the address
  assign slv_sel_o[SLV_SRAM] = in_region(req_i.haddr, `SRAM_BASE, `SRAM_SIZE);
  assign slv_sel_o[SLV_REG]  = in_region(req_i.haddr, `REG_BASE, `REG_SIZE);

  // Request goes to every slave unchanged
  assign slv_req_o = req_i;

  // Slaves see the master HREADY to qualify their address phase
  assign hready_o = rsp_o.hready;

  // Advance the data phase select only when the bus moves
  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      data_sel_q <= '0;
    end else if (rsp_o.hready) begin
      data_sel_q <= slv_sel_o;
    end
  end

  // Response mux on the registered select
  // No slave registered means unmapped space
  // which answers zero data, OKAY, no wait
  always_comb begin
    rsp_o.hrdata = '0;
    rsp_o.hresp  = 1'b0;
    rsp_o.hready = 1'b1;
    for (int s = 0; s < `AHB_NB_SLAVES; s++) begin
      if (data_sel_q[s]) begin
        rsp_o = slv_rsp_i[s];
      end
    end
  end

  // Regions must not overlap
  a_sel_onehot: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    $onehot0(slv_sel_o)
  );

  // Stall holds the address phase select that the handover registers
  a_sel_hold: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    !rsp_o.hready |=> $stable(slv_sel_o)
  );

endmodule

//--- source/ahb_sram_slave.sv
`timescale 1ns/1ps
`include "ahb_cfg.svh"

module ahb_sram_slave (
  input  logic                  hclk,
  input  logic                  hreset_n,
  input  ahb_bus_pkg::ahb_req_t req_i,
  input  logic                  sel_i,
  input  logic                  hready_i,
  output ahb_bus_pkg::ahb_rsp_t rsp_o
);
  import ahb_bus_pkg::*;

  localparam int IDX_W = $clog2(`SRAM_DEPTH);

  logic [`AHB_DATA_W-1:0] mem [`SRAM_DEPTH];
  logic                   xfer;
  logic                   act_q;
  logic                   write_q;
  logic [IDX_W-1:0]       idx_q;
  logic [1:0]             boff_q;
  hsize_e                 size_q;
  logic [3:0]             be;

  // Valid transfer to this slave in the address phase
  assign xfer = sel_i && hready_i && (req_i.htrans == NONSEQ || req_i.htrans == SEQ);

  // Data phase flags
  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      act_q   <= 1'b0;
      write_q <= 1'b0;
    end else if (hready_i) begin
      act_q   <= xfer;
      write_q <= xfer && req_i.hwrite;
    end
  end

  // Address and size of the accepted transfer
  always_ff @(posedge hclk) begin
    if (xfer) begin
      idx_q  <= req_i.haddr[IDX_W+1:2];
      boff_q <= req_i.haddr[1:0];
      size_q <= req_i.hsize;
    end
  end

  // Byte lanes from size and low address bits
  always_comb begin
    case (size_q)
      BYTE:    be = 4'b0001 << boff_q;
      HALF:    be = 4'b0011 << {boff_q[1], 1'b0};
      default: be = 4'b1111;
    endcase
  end

  // Merge write data into the enabled lanes at the end of the data phase
  always_ff @(posedge hclk) begin
    if (write_q && hready_i) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          mem[idx_q][8*b +: 8] <= req_i.hwdata[8*b +: 8];
        end
      end
    end
  end

  // Zero wait, never errors
  assign rsp_o.hrdata = (act_q && !write_q) ? mem[idx_q] : '0;
  assign rsp_o.hresp  = 1'b0;
  assign rsp_o.hready = 1'b1;

  // Master keeps halfwords and words on their natural boundary
  a_aligned: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    act_q |-> (size_q == BYTE) || (size_q == HALF && !boff_q[0]) || (boff_q == 2'b00)
  );

endmodule

//--- source/ahb_reg_slave.sv
`timescale 1ns/1ps
`include "ahb_cfg.svh"

module ahb_reg_slave (
  input  logic                  hclk,
  input  logic                  hreset_n,
  input  ahb_bus_pkg::ahb_req_t req_i,
  input  logic                  sel_i,
  input  logic                  hready_i,
  output ahb_bus_pkg::ahb_rsp_t rsp_o
);
  import ahb_bus_pkg::*;
  import ahb_map_pkg::*;

  localparam int unsigned WAIT_N = `REG_WAIT;
  localparam int          CNT_W  = $clog2(WAIT_N + 1);
  localparam int          OFF_W  = $bits(reg_off_e);

  typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_ERR1, ST_ERR2} state_e;

  state_e                      state_q;
  state_e                      state_d;
  logic [CNT_W-1:0]            cnt_q;
  logic [CNT_W-1:0]            cnt_d;
  logic                        xfer;
  logic [OFF_W-1:0]            off;
  logic                        bad;
  logic [OFF_W-1:0]            off_q;
  logic                        write_q;
  logic                        err_q;
  logic                        done;
  logic                        hreadyout;
  logic [2:0][`AHB_DATA_W-1:0] scr_q;
  logic [`AHB_DATA_W-1:0]      rd_data;

  assign xfer = sel_i && hready_i && (req_i.htrans == NONSEQ || req_i.htrans == SEQ);
  assign off  = req_i.haddr[OFF_W+1:2];

  // Write to ID or unimplemented offset
  assign bad = (off > OFF_SCR2) || (req_i.hwrite && off == OFF_ID);

  // OKAY completion on the last wait count
  assign done      = (state_q == ST_WAIT) && (cnt_q == CNT_W'(WAIT_N));
  assign hreadyout = (state_q == ST_IDLE) || done || (state_q == ST_ERR2);

  // Wait counting, then OKAY or the error pair
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      ST_WAIT: begin
        if (cnt_q != CNT_W'(WAIT_N)) begin
          cnt_d = cnt_q + 1'b1;
        end
        if (err_q && cnt_q == CNT_W'(WAIT_N - 1)) begin
          state_d = ST_ERR1;
        end
      end
      ST_ERR1: state_d = ST_ERR2;
      default: ;
    endcase
    // Ready cycle ends the data phase, maybe starting the next one
    if (hreadyout) begin
      state_d = xfer ? ST_WAIT : ST_IDLE;
      cnt_d   = '0;
    end
  end

  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      write_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      if (xfer) begin
        write_q <= req_i.hwrite;
        err_q   <= bad;
      end
    end
  end

  // Offset of the accepted transfer
  always_ff @(posedge hclk) begin
    if (xfer) begin
      off_q <= off;
    end
  end

  // Scratch registers take whole words
  always_ff @(posedge hclk or negedge hreset_n) begin
    if (!hreset_n) begin
      scr_q <= '0;
    end else if (done && write_q) begin
      case (off_q)
        OFF_SCR0: scr_q[0] <= req_i.hwdata;
        OFF_SCR1: scr_q[1] <= req_i.hwdata;
        OFF_SCR2: scr_q[2] <= req_i.hwdata;
        default:  ;
      endcase
    end
  end

  always_comb begin
    case (off_q)
      OFF_ID:   rd_data = `REG_ID_VALUE;
      OFF_SCR0: rd_data = scr_q[0];
      OFF_SCR1: rd_data = scr_q[1];
      OFF_SCR2: rd_data = scr_q[2];
      default:  rd_data = '0;
    endcase
  end

  assign rsp_o.hrdata = (done && !write_q) ? rd_data : '0;
  assign rsp_o.hresp  = (state_q == ST_ERR1) || (state_q == ST_ERR2);
  assign rsp_o.hready = hreadyout;

  // Two-cycle ERROR, stalled first then ready
  a_err_pair: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    state_q == ST_ERR1 |->
      (rsp_o.hresp && !rsp_o.hready) ##1 (rsp_o.hresp && rsp_o.hready)
  );

endmodule

//--- source/ahb_subsys_top.sv
`timescale 1ns/1ps
`include "ahb_cfg.svh"

module ahb_subsys_top (
  input  logic                  hclk,
  input  logic                  hreset_n,
  input  ahb_bus_pkg::ahb_req_t req_i,
  output ahb_bus_pkg::ahb_rsp_t rsp_o
);
  import ahb_bus_pkg::*;
  import ahb_map_pkg::*;

  // Node to slave wiring
  ahb_req_t                  slv_req;
  logic [`AHB_NB_SLAVES-1:0] slv_sel;
  logic                      hready;
  ahb_rsp_t                  slv_rsp [`AHB_NB_SLAVES];

  ahb_node u_node (
    .hclk      (hclk),
    .hreset_n  (hreset_n),
    .req_i     (req_i),
    .rsp_o     (rsp_o),
    .slv_req_o (slv_req),
    .slv_sel_o (slv_sel),
    .hready_o  (hready),
    .slv_rsp_i (slv_rsp)
  );

  // Zero wait memory
  ahb_sram_slave u_sram (
    .hclk     (hclk),
    .hreset_n (hreset_n),
    .req_i    (slv_req),
    .sel_i    (slv_sel[SLV_SRAM]),
    .hready_i (hready),
    .rsp_o    (slv_rsp[SLV_SRAM])
  );

  // ID and scratch registers with wait states
  ahb_reg_slave u_reg (
    .hclk     (hclk),
    .hreset_n (hreset_n),
    .req_i    (slv_req),
    .sel_i    (slv_sel[SLV_REG]),
    .hready_i (hready),
    .rsp_o    (slv_rsp[SLV_REG])
  );

endmodule

//--- bench/ahb_subsys_tb.sv
`timescale 1ns/1ps
`include "ahb_cfg.svh"

module ahb_subsys_tb;
  import ahb_bus_pkg::*;
  import ahb_map_pkg::*;

  localparam int          CYCLE_LIMIT = 2000;
  localparam logic [31:0] UNMAPPED    = 32'h0002_0000;

  // One master transfer as queued and as seen in its data phase
  typedef struct packed {
    logic [31:0] addr;
    logic        write;
    hsize_e      size;
    logic [31:0] wdata;
  } xfer_t;

  // Expected outcome of one data phase
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
    logic [7:0]  cycles;
  } expect_t;

  logic     hclk;
  logic     hreset_n;
  ahb_req_t req;
  ahb_rsp_t rsp;

  integer      seed = 32'h48a9_aa14;
  int          errors = 0;
  int          checks = 0;
  int          completed = 0;
  int          cycle_cnt = 0;
  xfer_t       xq [$];
  logic [31:0] sram_shadow [`SRAM_DEPTH];
  logic [31:0] scr_shadow [3] = '{default: '0};

  // Data phase tracked by the checker
  logic  dp_act = 1'b0;
  logic  dp_err_stall;
  int    dp_cyc;
  xfer_t dp;

  ahb_subsys_top dut (.hclk(hclk), .hreset_n(hreset_n), .req_i(req), .rsp_o(rsp));

  // Active byte lanes as a bit mask
  function automatic logic [31:0] lane_mask(input logic [1:0] boff, input hsize_e size);
    logic [31:0] m;
    case (size)
      BYTE:    m = 32'h0000_00ff << (8 * boff);
      HALF:    m = 32'h0000_ffff << (16 * boff[1]);
      default: m = 32'hffff_ffff;
    endcase
    return m;
  endfunction

  // Expected read data, response and data phase length
  // Writes also update the shadow state
  function automatic expect_t ref_access(input xfer_t x);
    expect_t     e;
    logic [31:0] m;
    int unsigned off;
    e = '0;
    e.cycles = 8'd1;
    m = lane_mask(x.addr[1:0], x.size);
    if (x.addr >= `SRAM_BASE && x.addr < `SRAM_BASE + `SRAM_SIZE) begin
      off = (x.addr - `SRAM_BASE) >> 2;
      if (x.write) begin
        sram_shadow[off] = (sram_shadow[off] & ~m) | (x.wdata & m);
      end else begin
        e.rdata = sram_shadow[off];
      end
    end else if (x.addr >= `REG_BASE && x.addr < `REG_BASE + `REG_SIZE) begin
      off = (x.addr - `REG_BASE) >> 2;
      e.cycles = `REG_WAIT + 1;
      // Unimplemented offset or a write to the read-only ID
      if (off >= 4 || (x.write && off == 0)) begin
        e.err = 1'b1;
        e.cycles = `REG_WAIT + 2;
      end else if (x.write) begin
        scr_shadow[off - 1] = x.wdata;
      end else if (off == 0) begin
        e.rdata = `REG_ID_VALUE;
      end else begin
        e.rdata = scr_shadow[off - 1];
      end
    end
    return e;
  endfunction

  // SRAM fill value that depends on every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f;
  endfunction

  task automatic push_xfer(input logic [31:0] addr, input logic write, input hsize_e size,
                           input logic [31:0] wdata);
    xq.push_back('{addr: addr, write: write, size: size, wdata: wdata});
  endtask

  // Mix of SRAM, register and unmapped accesses aligned to their size
  task automatic push_random(input int n);
    logic [31:0] r;
    logic [31:0] addr;
    hsize_e      size;
    int          region;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      region = {$random(seed)} % 3;
      size = WORD;
      if (region == 0) begin
        size = hsize_e'({$random(seed)} % 3);
        addr = `SRAM_BASE + (r & (`SRAM_SIZE - 1));
      end else if (region == 1) begin
        addr = `REG_BASE + (r & (`REG_SIZE - 4));
      end else begin
        addr = UNMAPPED + (r & 32'h0000_0ffc);
      end
      addr = addr & ~((32'd1 << size) - 32'd1);
      push_xfer(addr, r[31], size, $random(seed));
    end
  endtask

  // Pipelined master
  // Address of the next transfer overlaps the data phase of the current one
  task automatic run_queue();
    xfer_t cur;
    logic  cur_valid;
    logic  ready;
    cur_valid = 1'b0;
    while (xq.size() != 0 || cur_valid) begin
      if (xq.size() != 0) begin
        req.haddr  = xq[0].addr;
        req.hwrite = xq[0].write;
        req.hsize  = xq[0].size;
        req.htrans = NONSEQ;
      end else begin
        req.htrans = IDLE;
      end
      if (cur_valid) begin
        req.hwdata = cur.wdata;
      end
      // Both phases held until HREADY is seen high mid-cycle
      do begin
        @(negedge hclk);
        ready = rsp.hready;
        @(posedge hclk);
        #1;
      end while (!ready);
      cur_valid = (xq.size() != 0);
      if (cur_valid) begin
        cur = xq.pop_front();
      end
    end
  endtask

  initial begin
    hclk = 1'b0;
    forever #5 hclk = ~hclk;
  end

  always @(posedge hclk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    wait (cycle_cnt >= CYCLE_LIMIT);
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("=== FAIL ===");
    $finish;
  end

  // Checker on the falling edge where requests and responses are settled
  always @(negedge hclk) begin
    expect_t     want;
    logic [31:0] m;
    if (hreset_n) begin
      if (dp_act) begin
        dp_cyc++;
        if (rsp.hready) begin
          dp.wdata = req.hwdata;
          want = ref_access(dp);
          // Only read lanes carry data
          m = dp.write ? 32'h0 : lane_mask(dp.addr[1:0], dp.size);
          completed++;
          checks += 3;
          assert (rsp.hresp === want.err) else begin
            errors++;
            $display("Fail at %0t: addr %h hresp %b, expected %b",
                     $time, dp.addr, rsp.hresp, want.err);
          end
          assert (dp_cyc == want.cycles && dp_err_stall == want.err) else begin
            errors++;
            $display("Fail at %0t: addr %h took %0d cycles, error stall %b, expected %0d, %b",
                     $time, dp.addr, dp_cyc, dp_err_stall, want.cycles, want.err);
          end
          assert ((rsp.hrdata & m) === (want.rdata & m)) else begin
            errors++;
            $display("Fail at %0t: addr %h read %h, expected %h",
                     $time, dp.addr, rsp.hrdata & m, want.rdata & m);
          end
        end else begin
          // ERROR only in the stall cycle right before completion
          dp_err_stall = rsp.hresp;
        end
      end
      // Accepted address phase opens the next data phase
      if (rsp.hready) begin
        dp_act = (req.htrans == NONSEQ || req.htrans == SEQ);
        dp = '{addr: req.haddr, write: req.hwrite, size: req.hsize, wdata: 32'h0};
        dp_cyc = 0;
        dp_err_stall = 1'b0;
      end
    end
  end

  initial begin
    hreset_n = 1'b0;
    req = '0;
    req.htrans = IDLE;
    req.hsize = WORD;
    req.hprot = 4'b0011;
    repeat (5) @(posedge hclk);
    #1;
    hreset_n = 1'b1;
    @(posedge hclk);
    #1;
    // Whole SRAM to known contents
    for (int a = 0; a < `SRAM_SIZE; a += 4) begin
      push_xfer(`SRAM_BASE + a, 1'b1, WORD, fill_word(`SRAM_BASE + a));
    end
    run_queue();
    // Lane merging inside a word
    push_xfer(32'h0000_0010, 1'b1, WORD, 32'h1122_3344);
    push_xfer(32'h0000_0012, 1'b1, HALF, 32'haabb_0000);
    push_xfer(32'h0000_0011, 1'b1, BYTE, 32'h0000_cc00);
    push_xfer(32'h0000_0010, 1'b0, WORD, 32'h0);
    push_xfer(32'h0000_03ff, 1'b1, BYTE, 32'h7700_0000);
    push_xfer(32'h0000_03fc, 1'b1, HALF, 32'h0000_1234);
    push_xfer(32'h0000_03fc, 1'b0, WORD, 32'h0);
    // Scratch write and read back
    push_xfer(`REG_BASE + 4 * OFF_SCR0, 1'b1, WORD, 32'hdead_beef);
    push_xfer(`REG_BASE + 4 * OFF_SCR2, 1'b1, WORD, 32'h0bad_f00d);
    push_xfer(`REG_BASE + 4 * OFF_SCR0, 1'b0, WORD, 32'h0);
    push_xfer(`REG_BASE + 4 * OFF_SCR2, 1'b0, WORD, 32'h0);
    push_xfer(`REG_BASE + 4 * OFF_SCR1, 1'b0, WORD, 32'h0);
    // ID read, ID write and offset 5, then the ID again
    push_xfer(`REG_BASE + 4 * OFF_ID, 1'b0, WORD, 32'h0);
    push_xfer(`REG_BASE + 4 * OFF_ID, 1'b1, WORD, 32'hffff_ffff);
    push_xfer(`REG_BASE + 4 * 5, 1'b0, WORD, 32'h0);
    push_xfer(`REG_BASE + 4 * 5, 1'b1, WORD, 32'h5555_aaaa);
    push_xfer(`REG_BASE + 4 * OFF_ID, 1'b0, WORD, 32'h0);
    // Unmapped space
    push_xfer(UNMAPPED, 1'b0, WORD, 32'h0);
    push_xfer(UNMAPPED + 32'h40, 1'b1, WORD, 32'h1357_9bdf);
    push_xfer(UNMAPPED + 32'h40, 1'b0, WORD, 32'h0);
    run_queue();
    push_random(200);
    run_queue();
    repeat (2) @(posedge hclk);
    $display("Checks %0d, errors %0d, transfers %0d", checks, errors, completed);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+source
source/ahb_bus_pkg.sv
source/ahb_map_pkg.sv
source/ahb_node.sv
source/ahb_sram_slave.sv
source/ahb_reg_slave.sv
source/ahb_subsys_top.sv
bench/ahb_subsys_tb.sv
